//--- src/uart_cfg_if.sv
// ==========================================================================
// uart_cfg_if
// Line configuration from the register decoder to the UART engines.
// ==========================================================================
`default_nettype none

interface uart_cfg_if
	import uart_pkg::*;
	();

	baud_div_t div;
	logic parity_en;
	logic size8;   // 0 = 7 bit data
	logic stop2;
	logic odd;
	logic clr;     // one cycle FIFO clear

	modport ctrl (output div, parity_en, size8, stop2, odd, clr);
	modport engine (input div, parity_en, size8, stop2, odd, clr);

endinterface

`default_nettype wire

//--- src/uart_fifo.sv
// ==========================================================================
// uart_fifo
// 16 word synchronous FIFO, head word readable without a clock.
// Push when full and pop when empty are ignored.
// ==========================================================================
`default_nettype none

module uart_fifo
	import uart_pkg::*;
(
	input  wire       clk,
	input  wire       rst,
	input  logic      push,
	input  logic      pop,
	input  logic      clr,
	input  rx_word_t  din,
	output rx_word_t  dout,
	output logic      full,
	output logic      empty
);

	rx_word_t mem [FIFO_DEPTH];
	fifo_level_t wr_ptr;
	fifo_level_t rd_ptr;
	fifo_level_t level;

	assign level = wr_ptr - rd_ptr;
	assign empty = (wr_ptr == rd_ptr);
	assign full = level[FIFO_ADDR_BITS];   // 16 words stored
	assign dout = mem[rd_ptr[FIFO_ADDR_BITS-1:0]];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full && !clr)
			mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= din;
	end

endmodule

`default_nettype wire

//--- src/uart_pkg.sv
// ==========================================================================
// uart_pkg
// UART side definitions: line format types, divisor width, FIFO sizing
// and the engine state encodings.
// ==========================================================================
`default_nettype none

package uart_pkg;

	typedef logic [7:0] baud_div_t;   // one bit lasts div + 1 clocks
	typedef logic [7:0] uart_byte_t;
	typedef logic [8:0] rx_word_t;    // parity error on top, byte below

	localparam int RX_PERR_BIT = 8;

	localparam int FIFO_ADDR_BITS = 4;
	localparam int FIFO_DEPTH = 1 << FIFO_ADDR_BITS;

	typedef logic [FIFO_ADDR_BITS:0] fifo_level_t;   // extra wrap bit

	localparam logic IDLE_LEVEL = 1'b1;   // idle and stop level

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

endpackage

`default_nettype wire

//--- src/uart_readback.sv
// ==========================================================================
// uart_readback
// Register read mux with registered read data, and the irq combine.
// ==========================================================================
`default_nettype none

module uart_readback
	import uart_pkg::*;
	import wb_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	input  wb_adr_t     rd_adr,
	uart_cfg_if.engine  cfg,
	input  logic        ie_tx,
	input  logic        ie_rx,
	input  logic        tx_full,
	input  logic        tx_idle,
	input  logic        rx_exist,
	input  rx_word_t    rx_head,
	output wb_dat_t     wb_dat_r,
	output logic        irq
);

	wb_dat_t rd_mux;

	assign irq = (ie_tx & ~tx_full) | (ie_rx & rx_exist);

	always_comb begin
		rd_mux = '0;
		case (rd_adr)
			REG_DATA: rd_mux = rx_head[7:0];
			REG_CTRL: begin
				rd_mux[CTRL_PAR_EN] = cfg.parity_en;
				rd_mux[CTRL_SIZE8] = cfg.size8;
				rd_mux[CTRL_STOP2] = cfg.stop2;
				rd_mux[CTRL_ODD] = cfg.odd;
			end
			REG_DIV: rd_mux = cfg.div;
			REG_STATUS: begin
				rd_mux[STAT_TX_FULL] = tx_full;
				rd_mux[STAT_RX_EXIST] = rx_exist;
				rd_mux[STAT_PAR_ERR] = rx_exist & rx_head[RX_PERR_BIT];
				rd_mux[STAT_TX_IDLE] = tx_idle;
			end
			REG_IE: begin
				rd_mux[IE_TX] = ie_tx;
				rd_mux[IE_RX] = ie_rx;
			end
			default: rd_mux = '0;   // unmapped
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			wb_dat_r <= '0;
		else
			wb_dat_r <= rd_mux;   // valid in the ack cycle
	end

endmodule

`default_nettype wire

//--- src/uart_reg_decode.sv
// ==========================================================================
// uart_reg_decode
// Wishbone classic slave: single cycle ack, CTRL/DIV/IE registers and
// the push, pop and clear strobes issued in the ack cycle.
// ==========================================================================
`default_nettype none

module uart_reg_decode
	import uart_pkg::*;
	import wb_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  wb_adr_t     wb_adr,
	input  wb_dat_t     wb_dat_w,
	output logic        wb_ack,
	uart_cfg_if.ctrl    cfg,
	output logic        ie_tx,
	output logic        ie_rx,
	output logic        tx_push,
	output uart_byte_t  tx_byte,
	output logic        rx_pop,
	output wb_adr_t     rd_adr
);

	logic req;
	logic wr_req;

	assign req = wb_cyc & wb_stb & ~wb_ack;   // new request, not yet acked
	assign wr_req = req & wb_we;
	assign rd_adr = wb_adr;   // readback samples in the request cycle

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wb_ack <= 1'b0;
			tx_push <= 1'b0;
			rx_pop <= 1'b0;
			cfg.clr <= 1'b0;
			cfg.div <= '0;
			cfg.parity_en <= 1'b0;
			cfg.size8 <= 1'b0;
			cfg.stop2 <= 1'b0;
			cfg.odd <= 1'b0;
			ie_tx <= 1'b0;
			ie_rx <= 1'b0;
		end else begin
			wb_ack <= req;
			tx_push <= wr_req && (wb_adr == REG_DATA);
			rx_pop <= req && !wb_we && (wb_adr == REG_DATA);
			cfg.clr <= wr_req && (wb_adr == REG_CTRL) && wb_dat_w[CTRL_CLR];
			if (wr_req) begin
				case (wb_adr)
					REG_CTRL: begin
						cfg.parity_en <= wb_dat_w[CTRL_PAR_EN];
						cfg.size8 <= wb_dat_w[CTRL_SIZE8];
						cfg.stop2 <= wb_dat_w[CTRL_STOP2];
						cfg.odd <= wb_dat_w[CTRL_ODD];
					end
					REG_DIV: cfg.div <= wb_dat_w;
					REG_IE: begin
						ie_tx <= wb_dat_w[IE_TX];
						ie_rx <= wb_dat_w[IE_RX];
					end
					default: ;   // data and status have no register here
				endcase
			end
		end
	end

	// payload for the tx FIFO
	always_ff @(posedge clk) begin
		if (wr_req)
			tx_byte <= wb_dat_w;
	end

endmodule

`default_nettype wire

//--- src/uart_rx_engine.sv
// ==========================================================================
// uart_rx_engine
// Receiver: line synchronizer, mid-bit sampling, parity and stop check.
// Words land in the RX FIFO with their parity error flag.
// ==========================================================================
`default_nettype none

module uart_rx_engine
	import uart_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	uart_cfg_if.engine  cfg,
	input  logic        uart_rx,
	input  logic        rx_pop,
	output logic        rx_exist,
	output rx_word_t    rx_head
);

	rx_state_t state;
	baud_div_t cnt;
	uart_byte_t shreg;
	uart_byte_t rx_byte;
	logic [2:0] sync;
	logic [2:0] bit_cnt;
	logic [2:0] last_bit;
	logic sample;
	logic par;
	logic perr;
	logic stop_cnt;
	logic push;
	logic fifo_empty;

	assign sample = sync[1];
	assign last_bit = cfg.size8 ? 3'd7 : 3'd6;
	assign rx_exist = !fifo_empty;
	// 7 bit frames sit one place high in the shifter
	assign rx_byte = cfg.size8 ? shreg : {1'b0, shreg[7:1]};
	assign push = (state == RX_STOP) && (cnt == '0) && (sample == IDLE_LEVEL)
		&& (!cfg.stop2 || stop_cnt);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sync <= {3{IDLE_LEVEL}};
			state <= RX_IDLE;
			cnt <= '0;
			bit_cnt <= '0;
			par <= 1'b0;
			perr <= 1'b0;
			stop_cnt <= 1'b0;
		end else begin
			sync <= {sync[1:0], uart_rx};
			if (state == RX_IDLE) begin
				if (sync[2:1] == 2'b10) begin   // falling edge
					cnt <= cfg.div >> 1;
					state <= RX_START;
				end
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				cnt <= cfg.div;
				case (state)
					RX_START: begin
						if (sample == IDLE_LEVEL) begin
							state <= RX_IDLE;   // glitch, not a start bit
						end else begin
							bit_cnt <= '0;
							par <= 1'b0;
							perr <= 1'b0;
							stop_cnt <= 1'b0;
							state <= RX_DATA;
						end
					end
					RX_DATA: begin
						par <= par ^ sample;
						if (bit_cnt == last_bit)
							state <= cfg.parity_en ? RX_PARITY : RX_STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
					RX_PARITY: begin
						perr <= par ^ sample ^ cfg.odd;
						state <= RX_STOP;
					end
					RX_STOP: begin
						if (sample != IDLE_LEVEL)
							state <= RX_IDLE;   // framing error, drop frame
						else if (cfg.stop2 && !stop_cnt)
							stop_cnt <= 1'b1;
						else
							state <= RX_IDLE;
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && cnt == '0)
			shreg <= {sample, shreg[7:1]};   // LSB first
	end

	uart_fifo u_rx_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (push),
		.pop   (rx_pop),
		.clr   (cfg.clr),
		.din   ({perr, rx_byte}),
		.dout  (rx_head),
		.full  (),
		.empty (fifo_empty)
	);

endmodule

`default_nettype wire

//--- src/uart_tx_engine.sv
// ==========================================================================
// uart_tx_engine
// Transmit FIFO and serializer: start bit, 7 or 8 data bits LSB first,
// optional parity, one or two stop bits.
// ==========================================================================
`default_nettype none

module uart_tx_engine
	import uart_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	uart_cfg_if.engine  cfg,
	input  logic        tx_push,
	input  uart_byte_t  tx_byte,
	output logic        tx_full,
	output logic        tx_idle,
	output logic        uart_tx
);

	tx_state_t state;
	baud_div_t cnt;
	uart_byte_t shreg;
	rx_word_t tx_word;
	logic [2:0] bit_cnt;
	logic [2:0] last_bit;
	logic par;
	logic stop_cnt;
	logic fifo_empty;
	logic pop;

	assign tx_idle = (state == TX_IDLE);
	assign pop = tx_idle && !fifo_empty;
	assign last_bit = cfg.size8 ? 3'd7 : 3'd6;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= TX_IDLE;
			uart_tx <= IDLE_LEVEL;
			cnt <= '0;
			bit_cnt <= '0;
			par <= 1'b0;
			stop_cnt <= 1'b0;
		end else if (state == TX_IDLE) begin
			if (pop) begin
				uart_tx <= ~IDLE_LEVEL;   // start bit
				cnt <= cfg.div;
				par <= 1'b0;
				state <= TX_START;
			end
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else begin
			cnt <= cfg.div;
			case (state)
				TX_START: begin
					uart_tx <= shreg[0];
					bit_cnt <= '0;
					state <= TX_DATA;
				end
				TX_DATA: begin
					par <= par ^ shreg[0];
					if (bit_cnt == last_bit) begin
						stop_cnt <= cfg.stop2;
						if (cfg.parity_en) begin
							uart_tx <= par ^ shreg[0] ^ cfg.odd;
							state <= TX_PARITY;
						end else begin
							uart_tx <= IDLE_LEVEL;
							state <= TX_STOP;
						end
					end else begin
						uart_tx <= shreg[1];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				TX_PARITY: begin
					uart_tx <= IDLE_LEVEL;
					state <= TX_STOP;
				end
				TX_STOP: begin
					if (stop_cnt)
						stop_cnt <= 1'b0;   // second stop bit
					else
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// data shifter, loaded on pop
	always_ff @(posedge clk) begin
		if (pop)
			shreg <= tx_word[7:0];
		else if (state == TX_DATA && cnt == '0)
			shreg <= shreg >> 1;
	end

	uart_fifo u_tx_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (tx_push),
		.pop   (pop),
		.clr   (cfg.clr),
		.din   ({1'b0, tx_byte}),
		.dout  (tx_word),
		.full  (tx_full),
		.empty (fifo_empty)
	);

endmodule

`default_nettype wire

//--- src/uart_wb_top.sv
// ==========================================================================
// uart_wb_top
// UART peripheral with a Wishbone classic slave port and one irq line.
// ==========================================================================
`default_nettype none

module uart_wb_top
	import uart_pkg::*;
	import wb_pkg::*;
(
	input  wire      clk,
	input  wire      rst,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_adr_t  wb_adr,
	input  wb_dat_t  wb_dat_w,
	output wb_dat_t  wb_dat_r,
	output logic     wb_ack,
	input  logic     uart_rx,
	output logic     uart_tx,
	output logic     irq
);

	uart_cfg_if cfg ();

	logic ie_tx;
	logic ie_rx;
	logic tx_push;
	uart_byte_t tx_byte;
	logic rx_pop;
	wb_adr_t rd_adr;
	logic tx_full;
	logic tx_idle;
	logic rx_exist;
	rx_word_t rx_head;

	uart_reg_decode u_decode (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_ack   (wb_ack),
		.cfg      (cfg.ctrl),
		.ie_tx    (ie_tx),
		.ie_rx    (ie_rx),
		.tx_push  (tx_push),
		.tx_byte  (tx_byte),
		.rx_pop   (rx_pop),
		.rd_adr   (rd_adr)
	);

	uart_tx_engine u_tx (
		.clk     (clk),
		.rst     (rst),
		.cfg     (cfg.engine),
		.tx_push (tx_push),
		.tx_byte (tx_byte),
		.tx_full (tx_full),
		.tx_idle (tx_idle),
		.uart_tx (uart_tx)
	);

	uart_rx_engine u_rx (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg.engine),
		.uart_rx  (uart_rx),
		.rx_pop   (rx_pop),
		.rx_exist (rx_exist),
		.rx_head  (rx_head)
	);

	uart_readback u_readback (
		.clk      (clk),
		.rst      (rst),
		.rd_adr   (rd_adr),
		.cfg      (cfg.engine),
		.ie_tx    (ie_tx),
		.ie_rx    (ie_rx),
		.tx_full  (tx_full),
		.tx_idle  (tx_idle),
		.rx_exist (rx_exist),
		.rx_head  (rx_head),
		.wb_dat_r (wb_dat_r),
		.irq      (irq)
	);

endmodule

`default_nettype wire

//--- src/wb_pkg.sv
// ==========================================================================
// wb_pkg
// Wishbone side definitions: bus widths, register map and bit positions.
// ==========================================================================
`default_nettype none

package wb_pkg;

	typedef logic [2:0] wb_adr_t;
	typedef logic [7:0] wb_dat_t;

	localparam wb_adr_t REG_DATA   = 3'd0;   // write pushes tx, read pops rx
	localparam wb_adr_t REG_CTRL   = 3'd1;
	localparam wb_adr_t REG_DIV    = 3'd2;
	localparam wb_adr_t REG_STATUS = 3'd3;   // read only
	localparam wb_adr_t REG_IE     = 3'd4;

	localparam int CTRL_PAR_EN = 0;
	localparam int CTRL_SIZE8  = 1;
	localparam int CTRL_STOP2  = 2;
	localparam int CTRL_ODD    = 3;
	localparam int CTRL_CLR    = 4;   // self clearing

	localparam int STAT_TX_FULL  = 0;
	localparam int STAT_RX_EXIST = 1;
	localparam int STAT_PAR_ERR  = 2;
	localparam int STAT_TX_IDLE  = 3;

	localparam int IE_TX = 0;
	localparam int IE_RX = 1;

endpackage

`default_nettype wire

//--- testbench/tb_uart_wb_top.sv
// ==========================================================================
// tb_uart_wb_top
// Testbench for the Wishbone UART: bus cycles, serial frame driver and
// register, loopback, parity, overflow, clear and irq scenarios.
// ==========================================================================
`default_nettype none

module tb_uart_wb_top
	import uart_pkg::*;
	import wb_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int N_FRAMES = 62;     // frames sent plus idle waits
	localparam int FRAME_BITS = 12;   // start, 8 data, parity, 2 stop
	localparam int MAX_DIV = 255;
	localparam int TIMEOUT_NS = N_FRAMES * FRAME_BITS * (MAX_DIV + 1) * CLK_PERIOD + 100000;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat_w;
	wb_dat_t wb_dat_r;
	logic wb_ack;
	logic uart_rx;
	logic uart_tx;
	logic irq;
	logic line_drv;
	logic line_val;
	integer seed;
	baud_div_t bit_div;   // copy of DIV for the frame driver
	wb_dat_t rd_val;

	uart_wb_top uut (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.uart_rx  (uart_rx),
		.uart_tx  (uart_tx),
		.irq      (irq)
	);

	uart_checker chk (
		.clk      (clk),
		.rst      (rst),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.irq      (irq)
	);

	assign uart_rx = line_drv ? line_val : uart_tx;   // loopback by default

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic wb_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		do
			@(negedge clk);
		while (!wb_ack);
		rd_val = wb_dat_r;
		@(negedge clk);   // stb held through the ack edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic write_reg(input wb_adr_t adr, input wb_dat_t dat);
		wb_cycle(1'b1, adr, dat);
	endtask

	task automatic read_reg(input wb_adr_t adr);
		wb_cycle(1'b0, adr, 8'h00);
	endtask

	task automatic set_div(input baud_div_t d);
		write_reg(REG_DIV, d);
		bit_div = d;
	endtask

	function automatic uart_byte_t rand_byte();
		logic [31:0] rnd;
		rnd = $random(seed);
		return rnd[7:0];
	endfunction

	task automatic send_byte(input uart_byte_t data);
		write_reg(REG_DATA, data);
		chk.add_expected_word(data, 1'b0);
	endtask

	task automatic wait_rx();
		do
			read_reg(REG_STATUS);
		while (!rd_val[STAT_RX_EXIST]);
	endtask

	task automatic hold_bit();
		repeat (int'(bit_div) + 1) @(negedge clk);
	endtask

	// 8 data bits, even parity, one stop bit
	task automatic send_frame(input uart_byte_t data, input logic bad_parity);
		@(negedge clk);
		line_drv = 1'b1;
		line_val = ~IDLE_LEVEL;
		hold_bit();
		for (int k = 0; k < 8; k++) begin
			line_val = data[k];
			hold_bit();
		end
		line_val = ^data ^ bad_parity;
		hold_bit();
		line_val = IDLE_LEVEL;
		hold_bit();
		line_drv = 1'b0;
	endtask

	initial begin
		int n;
		uart_byte_t b;
		clk = 1'b0;
		rst = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		line_drv = 1'b0;
		line_val = IDLE_LEVEL;
		seed = 32'h774991a7;
		bit_div = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		chk.expect_status(8'h08, 8'hff);   // only tx_idle after reset
		read_reg(REG_STATUS);
		read_reg(REG_CTRL);
		read_reg(REG_DIV);
		read_reg(REG_IE);
		read_reg(3'd5);
		set_div(8'h5a);
		write_reg(REG_CTRL, 8'h1f);
		write_reg(REG_IE, 8'h03);
		read_reg(REG_DIV);
		read_reg(REG_CTRL);
		read_reg(REG_IE);
		write_reg(REG_IE, 8'h00);

		// 8 bit loopback, no parity
		set_div(8'd15);
		write_reg(REG_CTRL, 8'h02);
		for (int g = 0; g < 20; g += n) begin
			n = (20 - g > 8) ? 8 : 20 - g;
			for (int i = 0; i < n; i++)
				send_byte(rand_byte());
			for (int i = 0; i < n; i++) begin
				wait_rx();
				read_reg(REG_DATA);
			end
		end

		// 7 bit, even/odd parity, one/two stop bits
		for (int m = 0; m < 4; m++) begin
			write_reg(REG_CTRL, {4'b0000, m[0], m[1], 1'b0, 1'b1});
			for (int i = 0; i < 4; i++)
				send_byte(rand_byte());
			for (int i = 0; i < 4; i++) begin
				wait_rx();
				read_reg(REG_DATA);
			end
		end

		// hand-built frames, the first with a wrong parity bit
		write_reg(REG_CTRL, 8'h03);
		b = rand_byte();
		chk.add_expected_word(b, 1'b1);
		send_frame(b, 1'b1);
		b = rand_byte();
		chk.add_expected_word(b, 1'b0);
		send_frame(b, 1'b0);
		wait_rx();
		chk.expect_status(8'h06, 8'h06);
		read_reg(REG_STATUS);
		read_reg(REG_DATA);
		wait_rx();
		chk.expect_status(8'h02, 8'h06);
		read_reg(REG_STATUS);
		read_reg(REG_DATA);

		// overflow at the slowest rate, one word in the shifter and 16 queued
		set_div(8'd255);
		write_reg(REG_CTRL, 8'h02);
		for (int i = 0; i < 18; i++) begin
			b = rand_byte();
			write_reg(REG_DATA, b);
			if (i < 17)
				chk.add_expected_word(b, 1'b0);
		end
		chk.expect_status(8'h01, 8'h01);
		read_reg(REG_STATUS);
		for (int i = 0; i < 17; i++) begin
			wait_rx();
			read_reg(REG_DATA);
		end
		repeat (2 * FRAME_BITS * (MAX_DIV + 1)) @(negedge clk);
		chk.expect_status(8'h08, 8'h0b);   // dropped byte never shows up
		read_reg(REG_STATUS);

		// clear while the first frame is still in its stop bit
		for (int i = 0; i < 3; i++)
			send_byte(rand_byte());
		wait_rx();
		write_reg(REG_CTRL, 8'h12);
		chk.expect_status(8'h00, 8'h03);
		read_reg(REG_STATUS);
		repeat (2 * FRAME_BITS * (MAX_DIV + 1)) @(negedge clk);
		chk.expect_status(8'h08, 8'h0b);
		read_reg(REG_STATUS);

		// irq from rx data and from tx space
		set_div(8'd15);
		write_reg(REG_IE, 8'h02);
		chk.expect_status(8'h08, 8'h0b);
		read_reg(REG_STATUS);
		send_byte(rand_byte());
		do
			read_reg(REG_STATUS);
		while (!(rd_val[STAT_RX_EXIST] && rd_val[STAT_TX_IDLE]));
		read_reg(REG_DATA);
		chk.expect_status(8'h08, 8'h0b);
		read_reg(REG_STATUS);
		write_reg(REG_IE, 8'h01);
		chk.expect_status(8'h08, 8'h0b);
		read_reg(REG_STATUS);
		write_reg(REG_IE, 8'h00);
		chk.expect_status(8'h08, 8'h0b);
		read_reg(REG_STATUS);

		repeat (4) @(negedge clk);
		$display("checks %0d, errors %0d, assertion failures %0d",
			chk.checks, chk.errors, uut.asrt.fails);
		if (chk.errors == 0 && uut.asrt.fails == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the test did not finish within %0d ns", TIMEOUT_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/uart_checker.sv
// ==========================================================================
// uart_checker
// Watches the Wishbone port, models the registers and the receive queue,
// and compares read data and irq against the model.
// ==========================================================================
`default_nettype none

module uart_checker
	import uart_pkg::*;
	import wb_pkg::*;
(
	input  wire      clk,
	input  wire      rst,
	input  logic     wb_we,
	input  wb_adr_t  wb_adr,
	input  wb_dat_t  wb_dat_w,
	input  wb_dat_t  wb_dat_r,
	input  logic     wb_ack,
	input  logic     irq
);
	timeunit 1ns;
	timeprecision 1ps;

	rx_word_t rx_model[$];         // words still to be read from DATA
	logic [15:0] status_exp[$];    // {mask, value}
	wb_dat_t ctrl_reg;
	wb_dat_t div_reg;
	wb_dat_t ie_reg;
	int checks = 0;
	int errors = 0;

	function automatic rx_word_t expected_rx(input uart_byte_t data, input logic size8,
		input logic par_en, input logic bad_parity);
		uart_byte_t kept;
		kept = size8 ? data : {1'b0, data[6:0]};   // bit 7 not sent in 7 bit mode
		return {par_en & bad_parity, kept};
	endfunction

	task automatic add_expected_word(input uart_byte_t data, input logic bad_parity);
		rx_model.push_back(expected_rx(data, ctrl_reg[CTRL_SIZE8], ctrl_reg[CTRL_PAR_EN],
			bad_parity));
	endtask

	task automatic expect_status(input wb_dat_t value, input wb_dat_t mask);
		status_exp.push_back({mask, value});
	endtask

	task automatic compare(input string name, input wb_dat_t exp, input wb_dat_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0d ns %s expected %02h actual %02h", $time, name, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("[ERROR] %0d ns %s", $time, what);
	endtask

	always @(negedge clk) begin
		rx_word_t head;
		logic [15:0] st;
		logic irq_exp;
		if (!rst) begin
			ctrl_reg = '0;
			div_reg = '0;
			ie_reg = '0;
		end else if (wb_ack && wb_we) begin
			case (wb_adr)
				REG_CTRL: begin
					ctrl_reg = wb_dat_w & 8'h0f;   // clear bit reads 0
					if (wb_dat_w[CTRL_CLR])
						rx_model.delete();
				end
				REG_DIV: div_reg = wb_dat_w;
				REG_IE: ie_reg = wb_dat_w & 8'h03;
				default: ;
			endcase
		end else if (wb_ack) begin
			case (wb_adr)
				REG_DATA: begin
					if (rx_model.size() == 0) begin
						report_failure("DATA was read while no received word was expected");
					end else begin
						head = rx_model.pop_front();
						compare("wb_dat_r", head[7:0], wb_dat_r);
					end
				end
				REG_CTRL: compare("wb_dat_r", ctrl_reg, wb_dat_r);
				REG_DIV: compare("wb_dat_r", div_reg, wb_dat_r);
				REG_IE: compare("wb_dat_r", ie_reg, wb_dat_r);
				REG_STATUS: begin
					if (status_exp.size() != 0) begin
						st = status_exp.pop_front();
						compare("wb_dat_r", st[7:0], wb_dat_r & st[15:8]);
					end
					if (wb_dat_r[STAT_RX_EXIST] && rx_model.size() == 0)
						report_failure("a word was received that was never sent");
					else if (wb_dat_r[STAT_RX_EXIST])
						compare("wb_dat_r", {5'b0, rx_model[0][RX_PERR_BIT], 2'b0},
							wb_dat_r & (8'h01 << STAT_PAR_ERR));
					// irq only compared while nothing can move between sample and ack
					if (wb_dat_r[STAT_TX_IDLE] && !wb_dat_r[STAT_TX_FULL]) begin
						irq_exp = ie_reg[IE_TX] | (ie_reg[IE_RX] & wb_dat_r[STAT_RX_EXIST]);
						compare("irq", {7'b0, irq_exp}, {7'b0, irq});
					end
				end
				default: compare("wb_dat_r", 8'h00, wb_dat_r);   // unmapped
			endcase
		end
	end

endmodule

`default_nettype wire

//--- testbench/uart_wb_assertions.sv
// ==========================================================================
// uart_wb_assertions
// Bus handshake and idle line properties, bound into the UART top level.
// ==========================================================================
`default_nettype none

module uart_wb_assertions
	import uart_pkg::*;
(
	input  wire   clk,
	input  wire   rst,
	input  logic  wb_cyc,
	input  logic  wb_stb,
	input  logic  wb_ack,
	input  logic  uart_tx,
	input  logic  tx_idle
);
	timeunit 1ns;
	timeprecision 1ps;

	int fails = 0;

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst) wb_ack |=> !wb_ack)
		else begin
			fails++;
			$error("wb_ack high for two cycles in a row");
		end

	ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
		wb_ack |-> (wb_cyc && wb_stb))
		else begin
			fails++;
			$error("wb_ack high without wb_cyc and wb_stb");
		end

	idle_line: assert property (@(posedge clk) disable iff (!rst)
		tx_idle |-> (uart_tx == IDLE_LEVEL))
		else begin
			fails++;
			$error("uart_tx not at idle level while the transmitter is idle");
		end

endmodule

bind uart_wb_top uart_wb_assertions asrt (
	.clk     (clk),
	.rst     (rst),
	.wb_cyc  (wb_cyc),
	.wb_stb  (wb_stb),
	.wb_ack  (wb_ack),
	.uart_tx (uart_tx),
	.tx_idle (tx_idle)
);

`default_nettype wire

//--- uart_wb_top.f
src/uart_pkg.sv
src/wb_pkg.sv
src/uart_cfg_if.sv
src/uart_reg_decode.sv
src/uart_fifo.sv
src/uart_tx_engine.sv
src/uart_rx_engine.sv
src/uart_readback.sv
src/uart_wb_top.sv
testbench/uart_wb_assertions.sv
testbench/uart_checker.sv
testbench/tb_uart_wb_top.sv
